// ==== common/slice_pkg.sv ====
// shared widths, function codes and word formats of the data slice, imported by every RTL module
`default_nettype none

package slice_pkg;

   localparam int data_w    = 8;   // datapath byte
   localparam int reg_count = 26;  // physical registers
   localparam int addr_w    = 4;   // register address field
   localparam int bank_w    = 3;   // G register

   // function codes carried in the micro-operation
   typedef enum logic [2:0]
   {
      fn_add  = 3'd0,
      fn_adc  = 3'd1,
      fn_sub  = 3'd2,
      fn_and  = 3'd3,
      fn_or   = 3'd4,
      fn_xor  = 3'd5,
      fn_mov  = 3'd6,
      fn_setg = 3'd7
   } alu_fn_e;

   // register form, both operands from the file
   typedef struct packed
   {
      logic              form;    // 1 here
      alu_fn_e           fn;
      logic [3:0]        spare;   // ignored
      logic [addr_w-1:0] addr_b;
      logic [addr_w-1:0] addr_a;
   } reg_form_t;

   // immediate form, operand b is a literal byte
   typedef struct packed
   {
      logic              form;    // 0 here
      alu_fn_e           fn;
      logic [data_w-1:0] imm;
      logic [addr_w-1:0] addr_a;
   } imm_form_t;

   // bit 15 tells which view is valid
   typedef union packed
   {
      reg_form_t reg_view;
      imm_form_t imm_view;
   } micro_op_u;

   typedef struct packed
   {
      logic c;   // carry, borrow after sub
      logic v;   // overflow
      logic z;   // zero
      logic n;   // negative
   } flags_t;

   // output stream word
   typedef struct packed
   {
      logic [data_w-1:0] data;
      flags_t            flags;
   } slice_result_t;

endpackage

`default_nettype wire

// ==== design/regfile/reg_file.sv ====
// 26x8 register file with G-banked low addresses, two async read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module reg_file import slice_pkg::*;
(
   input  logic              pin_clk,
   input  logic              arst_n,
   input  logic [bank_w-1:0] g,        // current bank
   input  logic [addr_w-1:0] addr_a,   // read a, also write target
   input  logic [addr_w-1:0] addr_b,
   input  logic              wr_en,
   input  logic [data_w-1:0] wr_data,
   output logic [data_w-1:0] rd_a,
   output logic [data_w-1:0] rd_b
);

   logic [data_w-1:0]            regs [reg_count];
   logic [$clog2(reg_count)-1:0] idx_a;   // physical index, port a
   logic [$clog2(reg_count)-1:0] idx_b;   // physical index, port b

   // maps a 4-bit address and the bank to one of the 26 registers
   function automatic logic [$clog2(reg_count)-1:0] reg_index
   (
      input logic [addr_w-1:0] addr,
      input logic [bank_w-1:0] bank
   );
      logic [$clog2(reg_count)-1:0] idx;
      if (addr[addr_w-1:1] != '0)
      begin
         idx = 5'd27 - {1'b0, addr};   // 2..15 -> 25..12
      end
      else if (bank == 3'd6)
      begin
         idx = 5'd15 - {4'b0, addr[0]};   // aliases r15/r14
      end
      else if (bank == 3'd7)
      begin
         idx = 5'd13 - {4'b0, addr[0]};   // aliases r13/r12
      end
      else
      begin
         idx = {1'b0, bank, addr[0]};   // 2G, 2G+1
      end
      return idx;
   endfunction

   assign idx_a = reg_index(addr_a, g);
   assign idx_b = reg_index(addr_b, g);

   assign rd_a = regs[idx_a];
   assign rd_b = regs[idx_b];

   // whole file is cleared, not only the low twelve
   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < reg_count; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         regs[idx_a] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== design/alu/slice_alu.sv ====
// combinational byte ALU, per-bit OR/AND subfunction tables feeding a ripple carry chain
`timescale 1ns/1ps
`default_nettype none

module slice_alu import slice_pkg::*;
(
   input  logic [data_w-1:0] a,
   input  logic [data_w-1:0] b,
   input  alu_fn_e           fn,
   input  logic              carry_in,   // current C flag
   output logic [data_w-1:0] result,
   output flags_t            flags
);

   logic [3:0]        or_tab;    // ax per {a,b}
   logic [3:0]        and_tab;   // ay per {a,b}
   logic              cin;       // chain carry-in
   logic              arith;     // flags from the chain
   logic              borrow;    // invert carry out
   logic [data_w-1:0] ax;        // OR subfunction
   logic [data_w-1:0] ay;        // AND subfunction
   logic [data_w-1:0] c;         // carry out of each bit

   // table bits indexed by {a[i], b[i]}
   always_comb
   begin
      or_tab  = 4'b1010;   // pass b
      and_tab = 4'b0000;
      cin     = 1'b0;
      arith   = 1'b0;
      borrow  = 1'b0;
      case (fn)
         fn_add, fn_adc:
         begin
            or_tab  = 4'b0110;   // a ^ b
            and_tab = 4'b1000;   // a & b
            cin     = (fn == fn_adc) ? carry_in : 1'b0;
            arith   = 1'b1;
         end
         fn_sub:
         begin
            or_tab  = 4'b1001;   // a ^ ~b
            and_tab = 4'b0100;   // a & ~b
            cin     = 1'b1;      // two's complement +1
            arith   = 1'b1;
            borrow  = 1'b1;
         end
         fn_and: or_tab = 4'b1000;
         fn_or:  or_tab = 4'b1110;
         fn_xor: or_tab = 4'b0110;
         default: or_tab = 4'b1010;   // mov and setg give b
      endcase
   end

   for (genvar i = 0; i < data_w; i++)
   begin : gen_bit
      assign ax[i] = or_tab[{a[i], b[i]}];
      assign ay[i] = and_tab[{a[i], b[i]}];
   end

   assign c[0]      = ay[0] | ax[0] & cin;
   assign result[0] = ax[0] ^ cin;

   for (genvar i = 1; i < data_w; i++)
   begin : gen_chain
      assign c[i]      = ay[i] | ax[i] & c[i-1];
      assign result[i] = ax[i] ^ c[i-1];
   end

   always_comb
   begin
      flags.c = arith ? (c[data_w-1] ^ borrow) : carry_in;
      flags.v = arith & (c[data_w-1] ^ c[data_w-2]);   // carry into vs out of msb
      flags.z = (result == '0);
      flags.n = result[data_w-1];
   end

endmodule

`default_nettype wire

// ==== design/status_regs.sv ====
// PSW flag register and G bank register, updated on each accepted micro-operation
`timescale 1ns/1ps
`default_nettype none

module status_regs import slice_pkg::*;
(
   input  logic              pin_clk,
   input  logic              arst_n,
   input  logic              fire,        // operation accepted
   input  alu_fn_e           fn,
   input  flags_t            alu_flags,
   input  logic [bank_w-1:0] g_load,      // from operand b
   output flags_t            psw,
   output logic [bank_w-1:0] g
);

   // setg only touches G, everything else only the flags
   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         psw <= '0;
         g   <= '0;
      end
      else if (fire)
      begin
         if (fn == fn_setg)
         begin
            g <= g_load;
         end
         else
         begin
            psw <= alu_flags;   // all four at once
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/data_slice.sv ====
// top of the byte data slice: decodes the micro-op stream, runs the datapath, registers results
`timescale 1ns/1ps
`default_nettype none

module data_slice import slice_pkg::*;
(
   input  logic          pin_clk,
   input  logic          arst_n,
   input  logic          op_valid,
   input  micro_op_u     op,
   output logic          op_ready,
   output logic          res_valid,
   output slice_result_t res,
   input  logic          res_ready
);

   logic              fire;       // op transfer this edge
   alu_fn_e           fn;
   logic [addr_w-1:0] addr_a;
   logic [data_w-1:0] rd_a;
   logic [data_w-1:0] rd_b;
   logic [data_w-1:0] opnd_b;     // register or immediate
   logic [data_w-1:0] alu_out;
   flags_t            alu_flags;
   flags_t            psw;
   logic [bank_w-1:0] g;
   logic              wr_en;

   // fn and addr_a sit in the same bits of both views
   assign fn     = op.reg_view.fn;
   assign addr_a = op.reg_view.addr_a;
   assign opnd_b = op.reg_view.form ? rd_b : op.imm_view.imm;

   assign op_ready = !res_valid || res_ready;
   assign fire     = op_valid && op_ready;
   assign wr_en    = fire && (fn != fn_setg);

   reg_file u_reg_file
   (
      .pin_clk (pin_clk),
      .arst_n  (arst_n),
      .g       (g),                     // bank before this op
      .addr_a  (addr_a),
      .addr_b  (op.reg_view.addr_b),
      .wr_en   (wr_en),
      .wr_data (alu_out),
      .rd_a    (rd_a),
      .rd_b    (rd_b)
   );

   slice_alu u_alu
   (
      .a        (rd_a),
      .b        (opnd_b),
      .fn       (fn),
      .carry_in (psw.c),
      .result   (alu_out),   // b for setg
      .flags    (alu_flags)
   );

   status_regs u_status
   (
      .pin_clk   (pin_clk),
      .arst_n    (arst_n),
      .fire      (fire),
      .fn        (fn),
      .alu_flags (alu_flags),
      .g_load    (opnd_b[bank_w-1:0]),
      .psw       (psw),
      .g         (g)
   );

   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         res_valid <= 1'b0;
      end
      else if (fire)
      begin
         res_valid <= 1'b1;
      end
      else if (res_ready)
      begin
         res_valid <= 1'b0;   // taken, nothing new
      end
   end

   // output word, flags as they stand after the op
   always_ff @(posedge pin_clk)
   begin
      if (fire)
      begin
         res.data  <= alu_out;
         res.flags <= (fn == fn_setg) ? psw : alu_flags;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_model.svh ====
// reference model of the register file, G and PSW, included inside the data slice testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] model_regs [26];   // physical registers
logic [2:0] model_g;
flags_t     model_psw;

// physical register behind an address, the two low addresses follow the bank
function automatic logic [4:0] phys_index(input logic [3:0] addr, input logic [2:0] bank);
   if (addr >= 4'd2)
      return 5'd25 - ({1'b0, addr} - 5'd2);   // 2 is r25, 15 is r12
   case (bank)
      3'd6: return 5'd15 - {4'd0, addr[0]};
      3'd7: return 5'd13 - {4'd0, addr[0]};
      default: return {2'b00, bank} * 5'd2 + {4'd0, addr[0]};
   endcase
endfunction

task automatic clear_model();
   for (int i = 0; i < 26; i++)
      model_regs[i] = 8'h00;
   model_g   = 3'd0;
   model_psw = '0;
endtask

// applies one accepted op to the model and returns the word the DUT should emit
function automatic slice_result_t expected_result(input micro_op_u u);
   logic [7:0]    a;
   logic [7:0]    b;
   logic [8:0]    sum;   // bit 8 is carry, or borrow for sub
   slice_result_t want;
   a = model_regs[phys_index(u.reg_view.addr_a, model_g)];
   b = u.reg_view.form ? model_regs[phys_index(u.reg_view.addr_b, model_g)] : u.imm_view.imm;
   case (u.reg_view.fn)
      fn_add: sum = {1'b0, a} + {1'b0, b};
      fn_adc: sum = {1'b0, a} + {1'b0, b} + {8'd0, model_psw.c};
      fn_sub: sum = {1'b0, a} - {1'b0, b};
      fn_and: sum = {1'b0, a & b};
      fn_or:  sum = {1'b0, a | b};
      fn_xor: sum = {1'b0, a ^ b};
      default: sum = {1'b0, b};   // mov and setg
   endcase
   want.data  = sum[7:0];
   want.flags = model_psw;
   if (u.reg_view.fn == fn_setg)
   begin
      model_g = b[2:0];   // flags untouched
      return want;
   end
   want.flags.v = 1'b0;
   if (u.reg_view.fn inside {fn_add, fn_adc, fn_sub})
      want.flags.c = sum[8];
   if (u.reg_view.fn inside {fn_add, fn_adc})
      want.flags.v = (a[7] == b[7]) && (sum[7] != a[7]);
   if (u.reg_view.fn == fn_sub)
      want.flags.v = (a[7] != b[7]) && (sum[7] != a[7]);
   want.flags.z = (sum[7:0] == 8'h00);
   want.flags.n = sum[7];
   model_psw = want.flags;
   model_regs[phys_index(u.reg_view.addr_a, model_g)] = want.data;
   return want;
endfunction

`endif

// ==== testbench/tb_data_slice.sv ====
// testbench for data_slice that drives micro-op streams and checks every result against a model
`timescale 1ns/1ps
`default_nettype none

module tb_data_slice import slice_pkg::*;
();

   localparam int total_ops   = 1 + 200 + 100 + 52 + 150;
   localparam int watchdog_ns = 4 * total_ops * 4 + 2000;

   logic          pin_clk    = 1'b0;
   logic          arst_n;
   logic          op_valid;
   micro_op_u     op;
   logic          op_ready;
   logic          res_valid;
   slice_result_t res;
   logic          res_ready  = 1'b1;
   logic          stall_mode = 1'b0;   // random res_ready when set
   micro_op_u     op_q [$];            // ops still to drive
   slice_result_t exp_q [$];           // expected words in order
   string         name_q [$];
   string         test_name;
   slice_result_t got_want;
   string         got_name;

   `include "tb_model.svh"

   data_slice uut
   (
      .pin_clk   (pin_clk),
      .arst_n    (arst_n),
      .op_valid  (op_valid),
      .op        (op),
      .op_ready  (op_ready),
      .res_valid (res_valid),
      .res       (res),
      .res_ready (res_ready)
   );

   always #2 pin_clk = ~pin_clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("Error: %s expected %0h actual %0h", name, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   endtask

   function automatic micro_op_u imm_op(input alu_fn_e fn, input logic [7:0] imm,
                                        input logic [3:0] addr);
      micro_op_u u;
      u.imm_view = '{1'b0, fn, imm, addr};
      return u;
   endfunction

   function automatic micro_op_u reg_op(input alu_fn_e fn, input logic [3:0] a,
                                        input logic [3:0] b);
      micro_op_u u;
      u.reg_view = '{1'b1, fn, 4'd0, b, a};
      return u;
   endfunction

   function automatic micro_op_u random_op(input logic reg_form, input int max_fn);
      micro_op_u u;
      alu_fn_e   f;
      f = alu_fn_e'(3'($urandom_range(max_fn, 0)));
      if (reg_form)
         u.reg_view = '{1'b1, f, 4'($urandom), 4'($urandom), 4'($urandom)};   // spare too
      else
         u.imm_view = '{1'b0, f, 8'($urandom), 4'($urandom)};
      return u;
   endfunction

   // feeds op_q to the DUT and waits until every result is out
   task automatic run_queue(input string name);
      test_name = name;
      while (op_q.size() > 0 || op_valid)
      begin
         @(posedge pin_clk);
         if (!op_valid || op_ready)   // slot free or current op taken now
         begin
            op_valid <= (op_q.size() > 0);
            if (op_q.size() > 0)
               op <= op_q.pop_front();
         end
      end
      @(negedge pin_clk);
      while (exp_q.size() > 0)
         @(negedge pin_clk);
   endtask

   always @(posedge pin_clk)
      res_ready <= stall_mode ? (($urandom % 2) == 0) : 1'b1;

   // scoreboard updates the model on op transfers and compares on res transfers
   always @(posedge pin_clk)
   begin
      if (!arst_n)
      begin
         clear_model();
         exp_q.delete();
         name_q.delete();
      end
      else
      begin
         if (res_valid && res_ready && exp_q.size() == 0)
         begin
            $display("Error: a result came out with no operation pending");
            $display("FAIL: see errors above");
            $fatal(1);
         end
         else if (res_valid && res_ready)
         begin
            got_want = exp_q.pop_front();
            got_name = name_q.pop_front();
            check_value(got_name, {20'd0, got_want}, {20'd0, res});
         end
         if (res_valid && !res_ready)
            check_value("op_ready under stall", 32'd0, {31'd0, op_ready});
         if (op_valid && op_ready)
         begin
            exp_q.push_back(expected_result(op));
            name_q.push_back(test_name);
         end
      end
   end

   initial
   begin
      #(watchdog_ns);
      $display("watchdog: results stopped arriving, run cut off at %0t", $time);
      $display("FAIL: see errors above");
      $fatal(1);
   end

   initial
   begin
      void'($urandom(22557));
      arst_n   = 1'b0;
      op_valid = 1'b0;
      op       = '0;
      repeat (5) @(posedge pin_clk);
      arst_n <= 1'b1;
      @(negedge pin_clk);
      check_value("reset res_valid", 32'd0, {31'd0, res_valid});
      check_value("reset op_ready", 32'd1, {31'd0, op_ready});
      op_q.push_back(imm_op(fn_add, 8'h00, 4'd5));
      run_queue("reset add");
      repeat (200) op_q.push_back(random_op(1'b0, 6));   // no setg here
      run_queue("immediate");
      repeat (100) op_q.push_back(random_op(1'b1, 7));
      run_queue("register");
      for (int bank = 0; bank < 8; bank++)
      begin
         op_q.push_back(imm_op(fn_setg, 8'(bank), 4'd0));
         op_q.push_back(imm_op(fn_mov, 8'(8'h40 + 2 * bank), 4'd0));
         op_q.push_back(imm_op(fn_mov, 8'(8'h41 + 2 * bank), 4'd1));
      end
      for (int bank = 0; bank < 8; bank++)
      begin
         op_q.push_back(imm_op(fn_setg, 8'(bank), 4'd0));
         op_q.push_back(reg_op(fn_mov, 4'd0, 4'd0));   // reads back and rewrites the same value
         op_q.push_back(reg_op(fn_mov, 4'd1, 4'd1));
      end
      for (int addr = 12; addr < 16; addr++)
         op_q.push_back(reg_op(fn_mov, 4'(addr), 4'(addr)));   // aliases of banks 6 and 7
      run_queue("banking");
      stall_mode = 1'b1;
      repeat (150) op_q.push_back(random_op(($urandom % 2) == 0, 7));
      run_queue("back-pressure");
      stall_mode = 1'b0;
      if (!res_valid)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
      begin
         $display("a result was still offered after the last expected one was taken");
         $display("FAIL: see errors above");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
common/slice_pkg.sv
design/regfile/reg_file.sv
design/alu/slice_alu.sv
design/status_regs.sv
design/data_slice.sv
testbench/tb_data_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the data slice testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_data_slice -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "FAIL: see errors above" sim.log
then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "PASS: all tests" sim.log
then
   echo "simulation ended without a pass line"
   exit 1
fi
echo "simulation passed"
